//--- verilog.f
+incdir+rtl
rtl/wdog_pkg.sv
rtl/wdog_ctrl_if.sv
rtl/wdog_apb_regs.sv
rtl/wdog_resp_fsm.sv
rtl/wdog_timer.sv
rtl/wdog_apb_top.sv
verification/wdog_tb.sv

//--- Bender.yml
package:
  name: wdog_apb

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/wdog_pkg.sv
      - rtl/wdog_ctrl_if.sv
      - rtl/wdog_apb_regs.sv
      - rtl/wdog_resp_fsm.sv
      - rtl/wdog_timer.sv
      - rtl/wdog_apb_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/wdog_tb.sv

//--- verification/wdog_tb.sv
`timescale 1ns/100ps

`include "wdog_macros.svh"

module wdog_tb;

  localparam int N_RANDOM    = 300; // Random transfers in the first phase
  localparam int N_DIRECTED  = 80;  // Upper bound on directed transfers
  localparam int MAX_LOAD    = 55;  // Largest small LOAD value used
  localparam int SLACK       = 10;  // Cycles allowed past LOAD for a timeout
  // Reset, 4 cycles per transfer with idle, interrupt and reset waits, margin
  localparam int WDOG_CYCLES = 10 + (N_RANDOM + N_DIRECTED) * 4
                               + 3 * (MAX_LOAD + SLACK) + 500;

  logic                 PCLK;
  logic                 PRESETn;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  wdog_pkg::wdog_addr_t paddr;
  wdog_pkg::wdog_data_t pwdata;
  wdog_pkg::wdog_data_t prdata;
  logic                 pready;
  logic                 pslverr;
  logic                 wdog_int;
  logic                 wdog_res;

  // Reference model state
  wdog_pkg::wdog_data_t m_load;
  logic [1:0]           m_ctrl;
  logic                 m_locked;
  logic [31:0]          lcg_state;

  wdog_apb_top UUT
  (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .i_psel     (psel),
    .i_penable  (penable),
    .i_pwrite   (pwrite),
    .i_paddr    (paddr),
    .i_pwdata   (pwdata),
    .o_prdata   (prdata),
    .o_pready   (pready),
    .o_pslverr  (pslverr),
    .o_wdog_int (wdog_int),
    .o_wdog_res (wdog_res)
  );

  initial PCLK = 1'b0;
  always #20 PCLK = ~PCLK; // 40 ns period

  // ==================================================
  // Reporting
  // ==================================================
  task automatic finish_with_fail(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
      finish_with_fail($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                                 $time, what, got, exp));
  endtask

  task automatic check_true(input logic cond, input string reason);
    assert (cond)
    else
      finish_with_fail(reason);
  endtask

  // ==================================================
  // Stimulus helpers
  // ==================================================
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223; // Numerical Recipes LCG
    return lcg_state;
  endfunction

  function automatic wdog_pkg::wdog_addr_t random_addr();
    logic [31:0] r;
    r = next_random();
    case (r[31:29])
      3'd0:    return `WDOG_LOAD_ADDR;
      3'd1:    return `WDOG_VALUE_ADDR;
      3'd2:    return `WDOG_CTRL_ADDR;
      3'd3:    return `WDOG_INTCLR_ADDR;
      3'd4:    return `WDOG_RIS_ADDR;
      3'd5:    return `WDOG_MIS_ADDR;
      3'd6:    return `WDOG_LOCK_ADDR;
      default:
      begin
        // Random hole, pushed off the register map if it hits one
        if (r[19:10] inside {[10'h000:10'h005], `WDOG_LOCK_ADDR})
          return 10'h3FF;
        return r[19:10];
      end
    endcase
  endfunction

  // Illegal transfer rule, straight from the register map
  function automatic logic expect_illegal(input logic wr, input wdog_pkg::wdog_addr_t addr,
                                          input wdog_pkg::wdog_data_t data);
    if (wr)
      return !(addr inside {`WDOG_LOAD_ADDR, `WDOG_CTRL_ADDR, `WDOG_INTCLR_ADDR,
                            `WDOG_LOCK_ADDR}) || (addr == `WDOG_LOAD_ADDR && data == '0);
    return !(addr inside {`WDOG_LOAD_ADDR, `WDOG_VALUE_ADDR, `WDOG_CTRL_ADDR,
                          `WDOG_RIS_ADDR, `WDOG_MIS_ADDR, `WDOG_LOCK_ADDR});
  endfunction

  task automatic update_model(input wdog_pkg::wdog_addr_t addr,
                              input wdog_pkg::wdog_data_t data);
    case (addr)
      `WDOG_LOCK_ADDR: m_locked = (data != `WDOG_LOCK_KEY); // Always writable
      `WDOG_LOAD_ADDR: if (!m_locked) m_load = data;
      `WDOG_CTRL_ADDR: if (!m_locked) m_ctrl = data[1:0];
      default:         ;
    endcase
  endtask

  // ==================================================
  // APB driver
  // ==================================================
  task automatic bus_access(input logic wr, input wdog_pkg::wdog_addr_t addr,
                            input wdog_pkg::wdog_data_t wdata,
                            output wdog_pkg::wdog_data_t rdata, output logic err,
                            output int waits);
    waits = 0;
    @(posedge PCLK);
    psel    <= 1'b1; // Setup phase
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge PCLK);
    penable <= 1'b1; // Access phase
    @(negedge PCLK);
    while (!pready)
    begin
      waits++; // Error path inserts one
      @(negedge PCLK);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge PCLK);
    psel    <= 1'b0; // Back to idle
    penable <= 1'b0;
  endtask

  task automatic transfer_and_check(input logic wr, input wdog_pkg::wdog_addr_t addr,
                                    input wdog_pkg::wdog_data_t wdata,
                                    output wdog_pkg::wdog_data_t rdata);
    logic exp_err;
    logic err;
    int   waits;
    exp_err = expect_illegal(wr, addr, wdata);
    bus_access(wr, addr, wdata, rdata, err, waits);
    check_value($sformatf("PSLVERR at %h", addr), err, exp_err);
    check_value($sformatf("wait cycles at %h", addr), waits, exp_err ? 1 : 0);
    if (wr && !exp_err)
      update_model(addr, wdata);
    else if (!wr && exp_err)
      check_value("PRDATA on error", rdata, 32'h0);
    else if (!wr && addr == `WDOG_LOAD_ADDR)
      check_value("LOAD", rdata, m_load);
    else if (!wr && addr == `WDOG_CTRL_ADDR)
      check_value("CONTROL", rdata, {30'b0, m_ctrl});
    else if (!wr && addr == `WDOG_LOCK_ADDR)
      check_value("LOCK", rdata, {31'b0, m_locked});
  endtask

  task automatic write_reg(input wdog_pkg::wdog_addr_t addr, input wdog_pkg::wdog_data_t d);
    wdog_pkg::wdog_data_t unused;
    transfer_and_check(1'b1, addr, d, unused);
  endtask

  task automatic read_reg(input wdog_pkg::wdog_addr_t addr, output wdog_pkg::wdog_data_t d);
    transfer_and_check(1'b0, addr, '0, d);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial
  begin
    wdog_pkg::wdog_data_t rdata;
    wdog_pkg::wdog_data_t value_a;
    wdog_pkg::wdog_data_t value_b;
    wdog_pkg::wdog_data_t d;
    wdog_pkg::wdog_addr_t addr;
    logic [31:0]          r;
    int                   load_small;
    int                   cycles;
    PRESETn   = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    lcg_state = 32'h94eb_1fdc;
    m_load    = `WDOG_LOAD_RESET;
    m_ctrl    = 2'b00;
    m_locked  = 1'b0;
    repeat (10) @(posedge PCLK);
    PRESETn <= 1'b1;
    @(negedge PCLK);
    check_true(pready && !pslverr && !wdog_int && !wdog_res, "Outputs wrong after reset");

    // Random traffic over the map and holes
    for (int i = 0; i < N_RANDOM; i++)
    begin
      addr = random_addr();
      r    = next_random();
      d    = next_random();
      if (addr == `WDOG_LOCK_ADDR && r[5])
        d = `WDOG_LOCK_KEY; // Unlock about half the time
      if (addr == `WDOG_LOAD_ADDR && r[8:6] == 3'b000)
        d = '0;             // Zero LOAD, must error
      transfer_and_check(r[16], addr, d, rdata);
    end

    // LOAD and VALUE with the counter idle
    write_reg(`WDOG_LOCK_ADDR, `WDOG_LOCK_KEY);
    write_reg(`WDOG_CTRL_ADDR, 32'h0);
    repeat (5)
    begin
      d = next_random() | 32'h1;
      write_reg(`WDOG_LOAD_ADDR, d);
      read_reg(`WDOG_VALUE_ADDR, rdata);
      check_value("VALUE after LOAD", rdata, d);
    end
    write_reg(`WDOG_LOAD_ADDR, 32'h0);
    read_reg(`WDOG_LOAD_ADDR, rdata); // Model still holds the old LOAD

    // Lock and unlock
    d = next_random();
    if (d == `WDOG_LOCK_KEY)
      d = ~d;
    write_reg(`WDOG_LOCK_ADDR, d);
    read_reg(`WDOG_LOCK_ADDR, rdata);
    check_value("LOCK after non-key write", rdata, 32'h1);
    write_reg(`WDOG_LOAD_ADDR, next_random() | 32'h1);
    write_reg(`WDOG_CTRL_ADDR, next_random());
    read_reg(`WDOG_LOAD_ADDR, rdata);
    read_reg(`WDOG_CTRL_ADDR, rdata);
    write_reg(`WDOG_LOCK_ADDR, `WDOG_LOCK_KEY);
    read_reg(`WDOG_LOCK_ADDR, rdata);
    check_value("LOCK after key write", rdata, 32'h0);
    write_reg(`WDOG_LOAD_ADDR, next_random() | 32'h1);
    write_reg(`WDOG_CTRL_ADDR, next_random());
    read_reg(`WDOG_LOAD_ADDR, rdata);
    read_reg(`WDOG_CTRL_ADDR, rdata);

    // Interrupt on timeout
    write_reg(`WDOG_CTRL_ADDR, 32'h0);
    write_reg(`WDOG_INTCLR_ADDR, 32'h0); // Drop any stale RIS
    load_small = 24 + (next_random() % 32);
    write_reg(`WDOG_LOAD_ADDR, load_small);
    write_reg(`WDOG_CTRL_ADDR, 32'h1);
    cycles = 0;
    while (!wdog_int && cycles < load_small + SLACK)
    begin
      @(negedge PCLK);
      cycles++;
    end
    check_true(wdog_int, $sformatf("o_wdog_int did not rise within %0d cycles",
                                   load_small + SLACK));
    read_reg(`WDOG_RIS_ADDR, rdata);
    check_value("RIS after timeout", rdata, 32'h1);
    read_reg(`WDOG_MIS_ADDR, rdata);
    check_value("MIS after timeout", rdata, 32'h1);
    write_reg(`WDOG_INTCLR_ADDR, 32'h0);
    read_reg(`WDOG_RIS_ADDR, rdata);
    check_value("RIS after INTCLR", rdata, 32'h0);

    // Reset on a second timeout
    write_reg(`WDOG_CTRL_ADDR, 32'h0);
    write_reg(`WDOG_INTCLR_ADDR, 32'h0);
    load_small = 24 + (next_random() % 32);
    write_reg(`WDOG_LOAD_ADDR, load_small);
    write_reg(`WDOG_CTRL_ADDR, 32'h3);
    cycles = 0;
    while (!wdog_res && cycles < 2 * (load_small + SLACK))
    begin
      @(negedge PCLK);
      cycles++;
    end
    check_true(wdog_res, $sformatf("o_wdog_res did not rise within %0d cycles",
                                   2 * (load_small + SLACK)));
    read_reg(`WDOG_VALUE_ADDR, value_a);
    repeat (8) @(posedge PCLK);
    read_reg(`WDOG_VALUE_ADDR, value_b);
    check_value("VALUE while stopped", value_b, value_a);
    write_reg(`WDOG_LOAD_ADDR, 200 + (next_random() % 256)); // Restarts the count
    read_reg(`WDOG_VALUE_ADDR, value_a);
    read_reg(`WDOG_VALUE_ADDR, value_b);
    check_true(value_b < value_a, "Counter did not resume after the LOAD write");
    write_reg(`WDOG_CTRL_ADDR, 32'h0);
    @(negedge PCLK);
    check_true(!wdog_res, "o_wdog_res stayed high after the reset enable was cleared");

    $display(">>> PASS");
    $finish;
  end

  // Hang guard
  initial
  begin
    repeat (WDOG_CYCLES) @(posedge PCLK);
    finish_with_fail($sformatf("Watchdog expired after %0d cycles, test did not complete",
                               WDOG_CYCLES));
  end

endmodule

//--- rtl/wdog_apb_top.sv
`timescale 1ns/100ps

module wdog_apb_top
(
  input  logic                 PCLK,
  input  logic                 PRESETn,
  // APB
  input  logic                 i_psel,
  input  logic                 i_penable,
  input  logic                 i_pwrite,
  input  wdog_pkg::wdog_addr_t i_paddr,    // PADDR[11:2]
  input  wdog_pkg::wdog_data_t i_pwdata,
  output wdog_pkg::wdog_data_t o_prdata,
  output logic                 o_pready,
  output logic                 o_pslverr,
  // Watchdog
  output logic                 o_wdog_int,
  output logic                 o_wdog_res
);

  logic err; // Setup phase flagged illegal

  wdog_ctrl_if u_ctrl_if ();

  wdog_apb_regs u_regs
  (
    .PCLK      (PCLK),
    .PRESETn   (PRESETn),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .i_err     (err),
    .o_prdata  (o_prdata),
    .ctrl      (u_ctrl_if.regs)
  );

  wdog_resp_fsm u_resp
  (
    .PCLK      (PCLK),
    .PRESETn   (PRESETn),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_err     (err),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr)
  );

  wdog_timer u_timer
  (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .ctrl       (u_ctrl_if.timer),
    .o_wdog_int (o_wdog_int),
    .o_wdog_res (o_wdog_res)
  );

endmodule

//--- rtl/wdog_timer.sv
`timescale 1ns/100ps

`include "wdog_macros.svh"

module wdog_timer
(
  input  logic       PCLK,
  input  logic       PRESETn,
  wdog_ctrl_if.timer ctrl,
  output logic       o_wdog_int,
  output logic       o_wdog_res
);

  wdog_pkg::wdog_data_t reg_count;
  wdog_pkg::wdog_data_t count_mux;   // Reload or decremented value
  wdog_pkg::wdog_half_t cnt_lo;
  wdog_pkg::wdog_half_t cnt_hi;
  wdog_pkg::wdog_half_t nxt_count_low;
  wdog_pkg::wdog_half_t nxt_count_high;
  wdog_pkg::wdog_half_t high_count;  // Upper half feeding the carry
  logic                 nxt_carry_0;
  logic                 nxt_carry_1;
  logic [1:0]           reg_carry;
  logic                 carry_msb;   // Count hit zero, one cycle
  logic                 reload;
  logic                 count_run;
  logic                 int_en_reg;
  logic                 int_en_rise;
  logic                 stop_reg;
  logic                 res_set;
  logic                 int_clr_w;
  logic                 int_clr_reg;
  logic                 ris_reg;
  logic                 ris_read;
  logic                 res_reg;

  assign cnt_lo = reg_count[`WDOG_HALF_W-1:0];
  assign cnt_hi = reg_count[`WDOG_DATA_W-1:`WDOG_HALF_W];

  // ==================================================
  // Reload and run conditions
  // ==================================================
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      int_en_reg <= 1'b0;
    else
      int_en_reg <= ctrl.int_en;
  end

  assign int_en_rise = ctrl.int_en & ~int_en_reg;

  // New LOAD, timeout, interrupt enabled or cleared
  assign reload    = ctrl.load_wr | carry_msb | int_en_rise | int_clr_w;
  assign count_run = (ctrl.int_en & ~stop_reg) | ctrl.load_wr;

  // ==================================================
  // Split down-counter
  // ==================================================
  assign nxt_count_low = cnt_lo - 1'b1;

  always_comb
  begin
    if (reload)
      nxt_carry_0 = (ctrl.load_val[`WDOG_HALF_W-1:0] == '0);
    else
      nxt_carry_0 = (cnt_lo == wdog_pkg::wdog_half_t'(1)); // Low half about to wrap
  end

  // Upper half moves only on a registered borrow
  assign nxt_count_high = reg_carry[0] ? (cnt_hi - 1'b1) : cnt_hi;
  assign high_count = reload ? ctrl.load_val[`WDOG_DATA_W-1:`WDOG_HALF_W] : cnt_hi;
  assign nxt_carry_1 = (high_count == '0) & nxt_carry_0 & ~carry_msb;

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      reg_carry <= 2'b00;
    else if (count_run)
      reg_carry <= {nxt_carry_1, nxt_carry_0};
  end

  assign carry_msb = reg_carry[1];
  assign count_mux = reload ? ctrl.load_val : {nxt_count_high, nxt_count_low};

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      reg_count <= `WDOG_LOAD_RESET;
    else if (count_run)
      reg_count <= count_mux;
  end

  assign ctrl.count = reg_count; // VALUE read-back

  // Halted after a reset until LOAD is written again
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      stop_reg <= 1'b0;
    else if (ctrl.load_wr)
      stop_reg <= 1'b0;
    else if (res_set)
      stop_reg <= 1'b1;
  end

  // ==================================================
  // Interrupt
  // ==================================================
  // Clear held until the timeout carry has gone
  assign int_clr_w = ctrl.int_clr | (carry_msb & int_clr_reg);

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      int_clr_reg <= 1'b0;
      ris_reg     <= 1'b0;
    end
    else
    begin
      int_clr_reg <= int_clr_w;
      ris_reg     <= (carry_msb | ris_reg) & ~int_clr_w; // Sticky until cleared
    end
  end

  assign ris_read   = ris_reg & ~int_clr_w;
  assign ctrl.ris   = ris_read;
  assign ctrl.mis   = ris_read & ctrl.int_en;
  assign o_wdog_int = ctrl.mis;

  // ==================================================
  // Reset
  // ==================================================
  // Second timeout with the interrupt still pending
  assign res_set = ctrl.res_en & ris_reg & carry_msb;

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      res_reg <= 1'b0;
    else if (!ctrl.res_en)
      res_reg <= 1'b0; // Only a disable releases it
    else if (res_set)
      res_reg <= 1'b1;
  end

  assign o_wdog_res = res_reg;

endmodule

//--- rtl/wdog_resp_fsm.sv
`timescale 1ns/100ps

`include "wdog_macros.svh"

module wdog_resp_fsm
(
  input  logic                 PCLK,
  input  logic                 PRESETn,
  input  logic                 i_psel,
  input  logic                 i_penable,
  input  logic                 i_pwrite,
  input  wdog_pkg::wdog_addr_t i_paddr,
  input  wdog_pkg::wdog_data_t i_pwdata,
  output logic                 o_err,     // Illegal setup phase, combinational
  output logic                 o_pready,
  output logic                 o_pslverr
);

  logic                  wr_legal;  // Address takes writes
  logic                  rd_legal;  // Address takes reads
  logic                  load_zero; // Zero written to LOAD
  wdog_pkg::resp_state_t state_q;
  wdog_pkg::resp_state_t state_d;

  // ==================================================
  // Illegal transfer decode
  // ==================================================
  always_comb
  begin
    wr_legal = 1'b0;
    rd_legal = 1'b0;
    case (i_paddr)
      `WDOG_LOAD_ADDR,
      `WDOG_CTRL_ADDR,
      `WDOG_LOCK_ADDR:
      begin
        wr_legal = 1'b1;
        rd_legal = 1'b1;
      end
      `WDOG_INTCLR_ADDR: wr_legal = 1'b1; // Write only
      `WDOG_VALUE_ADDR:  rd_legal = 1'b1; // Status, read only
      `WDOG_RIS_ADDR:    rd_legal = 1'b1;
      `WDOG_MIS_ADDR:    rd_legal = 1'b1;
      default:           ; // Unmapped, both illegal
    endcase
  end

  assign load_zero = (i_paddr == `WDOG_LOAD_ADDR) && (i_pwdata == '0);

  assign o_err = i_psel & ~i_penable &
                 (i_pwrite ? (~wr_legal | load_zero) : ~rd_legal);

  // ==================================================
  // Response sequencing
  // ==================================================
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      state_q <= wdog_pkg::IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d   = state_q;
    o_pready  = 1'b1;
    o_pslverr = 1'b0;
    case (state_q)
      wdog_pkg::IDLE:      state_d = o_err ? wdog_pkg::NOT_READY : wdog_pkg::IDLE;
      wdog_pkg::NOT_READY:
      begin
        o_pready = 1'b0; // One wait cycle
        state_d  = wdog_pkg::ERROR;
      end
      wdog_pkg::ERROR:
      begin
        o_pslverr = 1'b1; // Completes with error
        state_d   = wdog_pkg::IDLE;
      end
      default:             state_d = wdog_pkg::IDLE;
    endcase
  end

endmodule

//--- rtl/wdog_apb_regs.sv
`timescale 1ns/100ps

`include "wdog_macros.svh"

module wdog_apb_regs
(
  input  logic                 PCLK,
  input  logic                 PRESETn,
  input  logic                 i_psel,
  input  logic                 i_penable,
  input  logic                 i_pwrite,
  input  wdog_pkg::wdog_addr_t i_paddr,
  input  wdog_pkg::wdog_data_t i_pwdata,
  input  logic                 i_err,    // Illegal setup phase from response FSM
  output wdog_pkg::wdog_data_t o_prdata,
  wdog_ctrl_if.regs            ctrl
);

  logic                 wr_setup;   // Legal write in setup phase
  logic                 rd_setup;   // Read in setup phase
  logic                 load_en;
  logic                 ctrl_en;
  logic                 intclr_en;
  logic                 lock_en;
  logic                 lock_q;     // 1 = locked
  wdog_pkg::wdog_ctrl_t ctrl_q;
  wdog_pkg::wdog_data_t load_q;
  logic                 load_wr_q;
  logic                 int_clr_q;
  wdog_pkg::wdog_data_t rd_word;
  wdog_pkg::wdog_data_t prdata_q;

  // ==================================================
  // Setup phase decode
  // ==================================================
  // Illegal transfers never reach a register
  assign wr_setup = i_psel & i_pwrite & ~i_penable & ~i_err;
  assign rd_setup = i_psel & ~i_pwrite & ~i_penable;

  // LOCK stays writable, the rest obey the lock bit
  assign lock_en   = wr_setup & (i_paddr == `WDOG_LOCK_ADDR);
  assign load_en   = wr_setup & ~lock_q & (i_paddr == `WDOG_LOAD_ADDR);
  assign ctrl_en   = wr_setup & ~lock_q & (i_paddr == `WDOG_CTRL_ADDR);
  assign intclr_en = wr_setup & ~lock_q & (i_paddr == `WDOG_INTCLR_ADDR);

  // ==================================================
  // Lock, control and load registers
  // ==================================================
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      lock_q <= `WDOG_LOCK_RESET;
    end
    else if (lock_en)
    begin
      lock_q <= (i_pwdata != `WDOG_LOCK_KEY); // Any non-key value locks
    end
  end

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      ctrl_q <= `WDOG_CTRL_RESET;
    end
    else if (ctrl_en)
    begin
      ctrl_q <= i_pwdata[`WDOG_CTRL_W-1:0];
    end
  end

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      load_q <= `WDOG_LOAD_RESET;
    end
    else if (load_en)
    begin
      load_q <= i_pwdata; // Zero already rejected as an error
    end
  end

  // Strobes, one cycle after the write
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      load_wr_q <= 1'b0;
      int_clr_q <= 1'b0;
    end
    else
    begin
      load_wr_q <= load_en;   // Lines up with the new load_q
      int_clr_q <= intclr_en;
    end
  end

  assign ctrl.load_val = load_q;
  assign ctrl.load_wr  = load_wr_q;
  assign ctrl.int_en   = ctrl_q[0];
  assign ctrl.res_en   = ctrl_q[1];
  assign ctrl.int_clr  = int_clr_q;

  // ==================================================
  // Read path
  // ==================================================
  always_comb
  begin
    rd_word = '0; // Unused bits read as zero
    case (i_paddr)
      `WDOG_LOAD_ADDR:  rd_word = load_q;
      `WDOG_VALUE_ADDR: rd_word = ctrl.count;
      `WDOG_CTRL_ADDR:  rd_word[`WDOG_CTRL_W-1:0] = ctrl_q;
      `WDOG_RIS_ADDR:   rd_word[0] = ctrl.ris;
      `WDOG_MIS_ADDR:   rd_word[0] = ctrl.mis;
      `WDOG_LOCK_ADDR:  rd_word[0] = lock_q;
      default:          rd_word = '0;
    endcase
  end

  // Captured at the setup edge, valid through the access phase
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      prdata_q <= '0;
    end
    else if (rd_setup && !i_err)
    begin
      prdata_q <= rd_word;
    end
    else
    begin
      prdata_q <= '0; // Errored or idle bus reads zero
    end
  end

  assign o_prdata = prdata_q;

endmodule

//--- rtl/wdog_ctrl_if.sv
`timescale 1ns/100ps

// Register file to timer link, all on PCLK
interface wdog_ctrl_if;

  // Register file side
  wdog_pkg::wdog_data_t load_val; // Current LOAD contents
  logic                 load_wr;  // One cycle, aligned with load_val
  logic                 int_en;   // CONTROL[0]
  logic                 res_en;   // CONTROL[1]
  logic                 int_clr;  // One cycle INTCLR strobe

  // Timer side
  wdog_pkg::wdog_data_t count;    // VALUE read-back
  logic                 ris;      // Raw interrupt status
  logic                 mis;      // Masked interrupt status

  modport regs
  (
    output load_val, load_wr, int_en, res_en, int_clr,
    input  count, ris, mis
  );

  modport timer
  (
    input  load_val, load_wr, int_en, res_en, int_clr,
    output count, ris, mis
  );

endinterface

//--- rtl/wdog_pkg.sv
`include "wdog_macros.svh"

package wdog_pkg;

  // ==================================================
  // Vector types
  // ==================================================
  typedef logic [`WDOG_DATA_W-1:0] wdog_data_t; // Register or bus word
  typedef logic [`WDOG_ADDR_W-1:0] wdog_addr_t; // APB word address
  typedef logic [`WDOG_HALF_W-1:0] wdog_half_t; // Counter half-word

  // Bit 0 interrupt enable, bit 1 reset enable
  typedef logic [`WDOG_CTRL_W-1:0] wdog_ctrl_t;

  // ==================================================
  // Error response FSM
  // ==================================================
  typedef enum logic [1:0]
  {
    IDLE      = 2'b00, // Transfer accepted, PREADY high
    NOT_READY = 2'b01, // Wait cycle ahead of the error
    ERROR     = 2'b10  // PREADY and PSLVERR both high
  } resp_state_t;

endpackage

//--- rtl/wdog_macros.svh
`ifndef WDOG_MACROS_SVH
`define WDOG_MACROS_SVH

// ==================================================
// Widths
// ==================================================
`define WDOG_DATA_W 32 // APB data and register word
`define WDOG_ADDR_W 10 // Word address, PADDR[11:2]
`define WDOG_HALF_W 16 // One counter half-word
`define WDOG_CTRL_W 2  // Interrupt and reset enables

// ==================================================
// Register word addresses
// ==================================================
`define WDOG_LOAD_ADDR   10'h000 // Byte offset 0x000
`define WDOG_VALUE_ADDR  10'h001 // Byte offset 0x004
`define WDOG_CTRL_ADDR   10'h002 // Byte offset 0x008
`define WDOG_INTCLR_ADDR 10'h003 // Byte offset 0x00C
`define WDOG_RIS_ADDR    10'h004 // Byte offset 0x010
`define WDOG_MIS_ADDR    10'h005 // Byte offset 0x014
`define WDOG_LOCK_ADDR   10'h300 // Byte offset 0xC00

// ==================================================
// Reset values and keys
// ==================================================
// Counter also comes out of reset at this value
`define WDOG_LOAD_RESET 32'hFFFF_FFFF

`define WDOG_CTRL_RESET 2'b00 // Interrupt and reset disabled
`define WDOG_LOCK_RESET 1'b0  // Unlocked after reset

// Only this value unlocks, anything else locks
`define WDOG_LOCK_KEY 32'h1ACC_E551

`endif
